// File: compile.f
logic/floor_ctrl_pkg.sv
logic/request_queue_if.sv
logic/button_latch.sv
logic/request_queue.sv
logic/dispatch_fsm.sv
logic/floor_request_ctrl.sv
verif/floor_request_ctrl_tb.sv

// File: logic/button_latch.sv
// Button lamp latch
`timescale 1ns/1ps

module button_latch import floor_ctrl_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t call_buttons,
    input  floor_mask_t panel_buttons,
    input  floor_t      current_floor,
    input  logic        serve_valid,
    input  floor_t      serve_floor,
    output floor_mask_t call_lights,
    output floor_mask_t panel_lights,
    request_queue_if.producer queue
);

    // Floors already handed to the queue or about to be
    floor_mask_t queued;

    floor_mask_t here_mask;
    floor_mask_t serve_mask;
    floor_mask_t pending;
    floor_mask_t grant;
    floor_t      grant_floor;

    //////////////////////////////
    // Masks
    //////////////////////////////

    // A press at the floor the car stands on is ignored
    assign here_mask  = floor_mask_t'(1) << current_floor;
    assign serve_mask = serve_valid ? (floor_mask_t'(1) << serve_floor) : '0;

    // Lit in either lamp set and not yet queued
    assign pending = (call_lights | panel_lights) & ~queued;

    // Lowest set bit wins
    assign grant = pending & (~pending + floor_mask_t'(1));

    always_comb begin
        grant_floor = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (grant[i]) begin
                grant_floor = floor_t'(i);
            end
        end
    end

    //////////////////////////////
    // Lamps and push register
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights      <= '0;
            panel_lights     <= '0;
            queued           <= '0;
            queue.push_valid <= 1'b0;
            queue.push_floor <= '0;
        end else if (queue.flush) begin
            call_lights      <= '0;
            panel_lights     <= '0;
            queued           <= '0;
            queue.push_valid <= 1'b0;
        end else begin
            call_lights  <= (call_lights | (call_buttons & ~here_mask)) & ~serve_mask;
            panel_lights <= (panel_lights | (panel_buttons & ~here_mask)) & ~serve_mask;

            // Mark the granted floor now so the next cycle picks another one
            queued           <= (queued | grant) & ~serve_mask;
            queue.push_valid <= |pending;
            queue.push_floor <= grant_floor;
        end
    end

    // A floor reaches the queue only once until it is served or flushed
    assert property (@(posedge clock) disable iff (!reset_n)
        queue.push_valid |->
            ($past(queued) & (floor_mask_t'(1) << queue.push_floor)) == '0
    ) else $error("button_latch: push of a floor that was already queued");

endmodule

// File: logic/dispatch_fsm.sv
// Car dispatch state machine
`timescale 1ns/1ps

module dispatch_fsm import floor_ctrl_pkg::*; (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   power_switch,
    input  logic   emergency_btn,
    input  logic   door_open_btn,
    input  logic   door_close_btn,
    input  floor_t current_floor,
    input  logic   move_ack,
    output logic   move_req,
    output logic   move_up,
    output floor_t move_target,
    output logic   serve_valid,
    output floor_t serve_floor,
    output logic   door_open_allowed,
    output logic   door_close_allowed,
    request_queue_if.consumer queue
);

    dispatch_state_t state;

    // No move in progress on either side of the handshake
    logic parked;

    //////////////////////////////
    // Combinational outputs
    //////////////////////////////

    assign queue.flush = !power_switch || emergency_btn;
    assign queue.pop   = (state == IDLE) && !queue.empty && !queue.flush;

    assign parked = (state != MOVING) && !move_ack;

    assign door_open_allowed  = door_open_btn && power_switch && parked;
    assign door_close_allowed = door_close_btn && power_switch && parked;

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state       <= IDLE;
            move_req    <= 1'b0;
            move_up     <= 1'b0;
            move_target <= '0;
            serve_valid <= 1'b0;
            serve_floor <= '0;
        end else begin
            serve_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (queue.pop) begin
                        if (queue.head_floor != current_floor) begin
                            // Direction fixed once for the whole trip
                            move_req    <= 1'b1;
                            move_target <= queue.head_floor;
                            move_up     <= (queue.head_floor > current_floor);
                            state       <= MOVING;
                        end else begin
                            // Already there, serve without moving
                            serve_valid <= 1'b1;
                            serve_floor <= queue.head_floor;
                        end
                    end
                end
                MOVING: begin
                    if (queue.flush) begin
                        move_req <= 1'b0;
                        state    <= RELEASE;
                    end else if (move_ack) begin
                        move_req    <= 1'b0;
                        serve_valid <= 1'b1;
                        serve_floor <= move_target;
                        state       <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Car must drop its ack before the next trip
                    if (!move_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Target and direction hold for the full request phase
    assert property (@(posedge clock) disable iff (!reset_n)
        move_req && $past(move_req) |-> $stable(move_target) && $stable(move_up)
    ) else $error("dispatch_fsm: move target changed while move_req high");

endmodule

// File: logic/floor_ctrl_pkg.sv
// Floor controller definitions
package floor_ctrl_pkg;

    //////////////////////////////
    // Sizing
    //////////////////////////////

    // Floors served by the car, numbered 0 to NUM_FLOORS-1
    localparam int NUM_FLOORS  = 11;
    localparam int FLOOR_W     = 4;

    // One slot per floor, since a floor is queued at most once
    localparam int QUEUE_DEPTH = NUM_FLOORS;
    localparam int COUNT_W     = $clog2(QUEUE_DEPTH + 1);
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [FLOOR_W-1:0]    floor_t;
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Dispatcher phases of the car handshake
    typedef enum logic [1:0] {
        IDLE,
        MOVING,
        RELEASE
    } dispatch_state_t;

endpackage

// File: logic/floor_request_ctrl.sv
// Floor request controller top
`timescale 1ns/1ps

module floor_request_ctrl import floor_ctrl_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    input  floor_t      current_floor,
    input  logic        move_ack,
    output logic        move_req,
    output floor_t      move_target,
    output logic        move_up,
    output floor_mask_t call_lights,
    output floor_mask_t panel_lights,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    // Arrival path from dispatcher back to the lamps
    logic   serve_valid;
    floor_t serve_floor;

    request_queue_if queue_if ();

    button_latch button_latch_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .current_floor (current_floor),
        .serve_valid   (serve_valid),
        .serve_floor   (serve_floor),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights),
        .queue         (queue_if.producer)
    );

    request_queue request_queue_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .queue   (queue_if.store)
    );

    dispatch_fsm dispatch_fsm_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .current_floor      (current_floor),
        .move_ack           (move_ack),
        .move_req           (move_req),
        .move_up            (move_up),
        .move_target        (move_target),
        .serve_valid        (serve_valid),
        .serve_floor        (serve_floor),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed),
        .queue              (queue_if.consumer)
    );

endmodule

// File: logic/request_queue.sv
// Floor request FIFO
`timescale 1ns/1ps

module request_queue import floor_ctrl_pkg::*; (
    input  logic clock,
    input  logic reset_n,
    request_queue_if.store queue
);

    floor_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [COUNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // Step a pointer around the circular buffer
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = queue.push_valid && !queue.flush;
    assign do_pop  = queue.pop && !queue.flush;

    assign queue.empty      = (count == '0);
    assign queue.head_floor = mem[rd_ptr];

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= queue.push_floor;
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (queue.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The dispatcher only pops what it can see
    assert property (@(posedge clock) disable iff (!reset_n)
        do_pop |-> count != '0
    ) else $error("request_queue: pop while empty");

    // Distinct floors never outnumber the slots
    assert property (@(posedge clock) disable iff (!reset_n)
        do_push |-> count != COUNT_W'(QUEUE_DEPTH)
    ) else $error("request_queue: push while full");

endmodule

// File: logic/request_queue_if.sv
// Request queue interface
`timescale 1ns/1ps

interface request_queue_if import floor_ctrl_pkg::*; ();

    // Write side, one floor per pulse
    logic   push_valid;
    floor_t push_floor;

    // Read side
    logic   pop;
    floor_t head_floor;
    logic   empty;

    // Drops every pending request, wins over push and pop
    logic   flush;

    modport producer (
        output push_valid,
        output push_floor,
        input  flush
    );

    modport store (
        input  push_valid,
        input  push_floor,
        input  pop,
        input  flush,
        output head_floor,
        output empty
    );

    modport consumer (
        output pop,
        output flush,
        input  head_floor,
        input  empty
    );

endinterface

// File: verif/floor_request_ctrl_tb.sv
// Floor request controller testbench
`timescale 1ns/1ps

module floor_request_ctrl_tb import floor_ctrl_pkg::*; ();

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 16;
    localparam int STIM_CYCLES  = 3000;
    // Longest travel, longest ack hold and handshake overhead of one trip
    localparam int WORST_DISPATCH = 16;
    localparam longint TIMEOUT_NS =
        longint'(RESET_CYCLES + STIM_CYCLES * WORST_DISPATCH) * PERIOD + 10000;

    logic        clock = 1'b0;
    logic        reset_n;
    floor_mask_t call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        move_ack;
    logic        move_req;
    floor_t      move_target;
    logic        move_up;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    int lamp_errors      = 0;
    int dispatch_errors  = 0;
    int handshake_errors = 0;
    int door_errors      = 0;

    // Reference model state
    floor_mask_t     m_call;
    floor_mask_t     m_panel;
    floor_mask_t     m_queued;
    logic            m_push_valid;
    floor_t          m_push_floor;
    floor_t          exp_q[$];
    dispatch_state_t m_state;
    logic            m_req;
    logic            m_up;
    floor_t          m_target;
    logic            m_serve;
    floor_t          m_serve_floor;
    int              model_cycles = 0;

    // Car responder and handshake history
    int     travel_cnt;
    int     hold_cnt;
    logic   prev_req    = 1'b0;
    logic   prev_ack    = 1'b0;
    floor_t prev_target = '0;

    floor_request_ctrl floor_request_ctrl_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_buttons       (call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .move_ack           (move_ack),
        .move_req           (move_req),
        .move_target        (move_target),
        .move_up            (move_up),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic print_error_counts();
        $display("Errors: lamp %0d, dispatch %0d, handshake %0d, door %0d",
                 lamp_errors, dispatch_errors, handshake_errors, door_errors);
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    always @(posedge clock) begin : reference_model
        floor_mask_t here;
        floor_mask_t served;
        floor_mask_t pending;
        floor_mask_t grant_mask;
        floor_t      grant_floor;
        floor_t      head;
        logic        flush;
        logic        pop;
        model_cycles++;
        if (!reset_n) begin
            m_call       = '0;
            m_panel      = '0;
            m_queued     = '0;
            m_push_valid = 1'b0;
            m_push_floor = '0;
            exp_q.delete();
            m_state      = IDLE;
            m_req        = 1'b0;
            m_up         = 1'b0;
            m_target     = '0;
            m_serve      = 1'b0;
            m_serve_floor = '0;
        end else begin
            flush   = !power_switch || emergency_btn;
            here    = floor_mask_t'(1) << current_floor;
            served  = m_serve ? (floor_mask_t'(1) << m_serve_floor) : '0;
            pending = (m_call | m_panel) & ~m_queued;
            // Lowest-numbered lit floor not yet queued goes out next
            grant_mask  = '0;
            grant_floor = '0;
            for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
                if (pending[i]) begin
                    grant_mask  = floor_mask_t'(1) << i;
                    grant_floor = floor_t'(i);
                end
            end
            pop     = (m_state == IDLE) && (exp_q.size() != 0) && !flush;
            head    = pop ? exp_q[0] : '0;
            m_serve = 1'b0;
            if (flush) begin
                m_call       = '0;
                m_panel      = '0;
                m_queued     = '0;
                m_push_valid = 1'b0;
                exp_q.delete();
            end else begin
                if (pop) begin
                    void'(exp_q.pop_front());
                end
                if (m_push_valid) begin
                    exp_q.push_back(m_push_floor);
                end
                m_call       = (m_call | (call_buttons & ~here)) & ~served;
                m_panel      = (m_panel | (panel_buttons & ~here)) & ~served;
                m_queued     = (m_queued | grant_mask) & ~served;
                m_push_valid = |pending;
                m_push_floor = grant_floor;
            end
            case (m_state)
                IDLE: begin
                    if (pop && head != current_floor) begin
                        m_req    = 1'b1;
                        m_target = head;
                        m_up     = head > current_floor;
                        m_state  = MOVING;
                    end else if (pop) begin
                        m_serve       = 1'b1;
                        m_serve_floor = head;
                    end
                end
                MOVING: begin
                    if (flush) begin
                        m_req   = 1'b0;
                        m_state = RELEASE;
                    end else if (move_ack) begin
                        m_req         = 1'b0;
                        m_serve       = 1'b1;
                        m_serve_floor = m_target;
                        m_state       = RELEASE;
                    end
                end
                default: begin
                    if (!move_ack) begin
                        m_state = IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // Checks at the falling edge
    //////////////////////////////

    always @(negedge clock) begin : output_checks
        logic open_exp;
        logic close_exp;
        if (model_cycles > 0) begin
            assert (call_lights == m_call) else begin
                lamp_errors++;
                $display("FAILED call_lights: expected %b actual %b", m_call, call_lights);
            end
            assert (panel_lights == m_panel) else begin
                lamp_errors++;
                $display("FAILED panel_lights: expected %b actual %b", m_panel, panel_lights);
            end
            assert (move_req == m_req) else begin
                dispatch_errors++;
                $display("FAILED move_req: expected %b actual %b", m_req, move_req);
            end
            if (m_req && move_req) begin
                assert (move_target == m_target) else begin
                    dispatch_errors++;
                    $display("FAILED move_target: expected %0d actual %0d",
                             m_target, move_target);
                end
                assert (move_up == m_up) else begin
                    dispatch_errors++;
                    $display("FAILED move_up: expected %b actual %b", m_up, move_up);
                end
            end
            assert (!(move_req && !prev_req && prev_ack)) else begin
                handshake_errors++;
                $display("move_req rose while the car still held move_ack high");
            end
            assert (!(move_req && prev_req && move_target != prev_target)) else begin
                handshake_errors++;
                $display("move_target changed while move_req was high");
            end
            // Doors only while parked with power on
            open_exp  = door_open_btn && power_switch && !m_req && !move_ack;
            close_exp = door_close_btn && power_switch && !m_req && !move_ack;
            assert (door_open_allowed == open_exp) else begin
                door_errors++;
                $display("FAILED door_open_allowed: expected %b actual %b",
                         open_exp, door_open_allowed);
            end
            assert (door_close_allowed == close_exp) else begin
                door_errors++;
                $display("FAILED door_close_allowed: expected %b actual %b",
                         close_exp, door_close_allowed);
            end
        end
        prev_req    = move_req;
        prev_ack    = move_ack;
        prev_target = move_target;
    end

    //////////////////////////////
    // Car responder
    //////////////////////////////

    always @(posedge clock) begin : car_responder
        #5;
        if (!reset_n) begin
            move_ack   = 1'b0;
            travel_cnt = 0;
            hold_cnt   = 0;
        end else if (move_ack) begin
            // Random hold after move_req falls stalls the dispatcher
            if (!move_req) begin
                if (hold_cnt == 0) begin
                    move_ack = 1'b0;
                end else begin
                    hold_cnt--;
                end
            end
        end else if (move_req) begin
            if (travel_cnt == 0) begin
                travel_cnt = $urandom_range(2, 8);
            end
            travel_cnt--;
            if (travel_cnt == 0) begin
                current_floor = move_target;
                move_ack      = 1'b1;
                hold_cnt      = $urandom_range(0, 5);
            end
        end else begin
            // Trip aborted by a flush
            travel_cnt = 0;
        end
    end

    //////////////////////////////
    // Stimulus and end of run
    //////////////////////////////

    initial begin : stimulus
        void'($urandom(15624));
        reset_n        = 1'b0;
        call_buttons   = '0;
        panel_buttons  = '0;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn  = 1'b0;
        power_switch   = 1'b1;
        current_floor  = '0;
        move_ack       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #5 reset_n = 1'b1;
        repeat (STIM_CYCLES) begin
            @(posedge clock);
            #5;
            // Sparse presses, about one bit in eight
            call_buttons   = floor_mask_t'($urandom & $urandom & $urandom);
            panel_buttons  = floor_mask_t'($urandom & $urandom & $urandom);
            door_open_btn  = ($urandom_range(0, 3) == 0);
            door_close_btn = ($urandom_range(0, 3) == 0);
            emergency_btn  = ($urandom_range(0, 99) == 0);
            power_switch   = ($urandom_range(0, 149) != 0);
        end
        @(posedge clock);
        #5;
        call_buttons  = '0;
        panel_buttons = '0;
        emergency_btn = 1'b0;
        power_switch  = 1'b1;
        // Let every lit floor be served and the car come to rest
        do begin
            @(posedge clock);
            #5;
        end while ((m_call | m_panel) != '0 || move_req || move_ack);
        repeat (4) @(posedge clock);
        print_error_counts();
        if (lamp_errors + dispatch_errors + handshake_errors + door_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog timeout, the controller never came to rest");
        print_error_counts();
        $display("TESTS FAILED");
        $finish;
    end

endmodule
